// File: list.f
rtl/core_pkg.sv
rtl/core_ifu.sv
rtl/core_regfile.sv
rtl/core_idu.sv
rtl/core_exu.sv
rtl/core_lsu.sv
rtl/core_top.sv
tb/core_checker.sv
tb/core_tb.sv

// File: rtl/core_exu.sv
// execute unit with the ALU, operand select and branch/jump resolution
`timescale 1ns/1ps

module core_exu import core_pkg::*; (
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_imm,
  input  alu_op_e         i_alu_op,
  input  src_b_e          i_src_b,
  input  br_op_e          i_br_op,
  output logic [XLEN-1:0] o_alu_result,
  output logic            o_branch_taken,
  output logic [XLEN-1:0] o_branch_target
);

  logic [XLEN-1:0] op_b;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic [XLEN-1:0] jalr_sum;

  assign op_b = (i_src_b == SRC_B_IMM) ? i_imm : i_rs2_data;

  // compares use the second operand so slt and branches share them
  assign eq   = (i_rs1_data == op_b);
  assign lt_s = $signed(i_rs1_data) < $signed(op_b);
  assign lt_u = i_rs1_data < op_b;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:    o_alu_result = i_rs1_data + op_b;
      ALU_SUB:    o_alu_result = i_rs1_data - op_b;
      ALU_AND:    o_alu_result = i_rs1_data & op_b;
      ALU_OR:     o_alu_result = i_rs1_data | op_b;
      ALU_XOR:    o_alu_result = i_rs1_data ^ op_b;
      ALU_SLT:    o_alu_result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   o_alu_result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_PASS_B: o_alu_result = op_b;
      default:    o_alu_result = '0;
    endcase
  end

  always_comb begin
    case (i_br_op)
      BR_EQ:   o_branch_taken = eq;
      BR_NE:   o_branch_taken = !eq;
      BR_LT:   o_branch_taken = lt_s;
      BR_GE:   o_branch_taken = !lt_s;
      BR_JAL:  o_branch_taken = 1'b1;
      BR_JALR: o_branch_taken = 1'b1;
      default: o_branch_taken = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;
  assign o_branch_target = (i_br_op == BR_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;

endmodule

// File: rtl/core_idu.sv
// instruction decoder for the supported RV64I subset, unknown encodings become no-ops
`timescale 1ns/1ps

module core_idu import core_pkg::*; (
  input  logic [31:0]       i_inst,
  output logic [REG_AW-1:0] o_rs1,
  output logic [REG_AW-1:0] o_rs2,
  output logic [REG_AW-1:0] o_rd,
  output logic [XLEN-1:0]   o_imm,
  output alu_op_e           o_alu_op,
  output src_b_e            o_src_b,
  output br_op_e            o_br_op,
  output wb_sel_e           o_wb_sel,
  output logic              o_rf_wen,
  output logic              o_mem_wen,
  output logic              o_halt_req
);

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            rf_wen_raw;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rs1  = i_inst[19:15];
  assign o_rs2  = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    o_imm      = imm_i;
    o_alu_op   = ALU_ADD;
    o_src_b    = SRC_B_REG;
    o_br_op    = BR_NONE;
    o_wb_sel   = WB_ALU;
    rf_wen_raw = 1'b0;
    o_mem_wen  = 1'b0;
    o_halt_req = 1'b0;
    case (opcode_e'(i_inst[6:0]))
      OPC_OP: begin
        rf_wen_raw = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: o_alu_op = ALU_SUB;
          {7'b0000000, 3'b010}: o_alu_op = ALU_SLT;
          {7'b0000000, 3'b011}: o_alu_op = ALU_SLTU;
          {7'b0000000, 3'b100}: o_alu_op = ALU_XOR;
          {7'b0000000, 3'b110}: o_alu_op = ALU_OR;
          {7'b0000000, 3'b111}: o_alu_op = ALU_AND;
          default: rf_wen_raw = 1'b0;
        endcase
      end
      // addi only
      OPC_OP_IMM: begin
        o_src_b    = SRC_B_IMM;
        rf_wen_raw = (funct3 == 3'b000);
      end
      OPC_LUI: begin
        o_imm      = imm_u;
        o_alu_op   = ALU_PASS_B;
        o_src_b    = SRC_B_IMM;
        rf_wen_raw = 1'b1;
      end
      OPC_LOAD: begin
        o_src_b    = SRC_B_IMM;
        o_wb_sel   = WB_MEM;
        rf_wen_raw = (funct3 == 3'b011);
      end
      OPC_STORE: begin
        o_imm     = imm_s;
        o_src_b   = SRC_B_IMM;
        o_mem_wen = (funct3 == 3'b011);
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000:  o_br_op = BR_EQ;
          3'b001:  o_br_op = BR_NE;
          3'b100:  o_br_op = BR_LT;
          3'b101:  o_br_op = BR_GE;
          default: o_br_op = BR_NONE;
        endcase
      end
      OPC_JAL: begin
        o_imm      = imm_j;
        o_br_op    = BR_JAL;
        o_wb_sel   = WB_PC4;
        rf_wen_raw = 1'b1;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_br_op    = BR_JALR;
          o_wb_sel   = WB_PC4;
          rf_wen_raw = 1'b1;
        end
      end
      // ebreak is the only system encoding honoured
      OPC_SYSTEM: o_halt_req = (i_inst == 32'h0010_0073);
      default: ;
    endcase
  end

  assign o_rf_wen = rf_wen_raw && (o_rd != '0);

  always_comb begin
    a_single_write: assert final (!(o_rf_wen && o_mem_wen))
      else $error("decoder enabled both register and memory writes");
  end

endmodule

// File: rtl/core_ifu.sv
// fetch unit holding the PC and the sticky halt flag, enables commits while running
`timescale 1ns/1ps

module core_ifu import core_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_branch_taken,
  input  logic [XLEN-1:0] i_branch_target,
  input  logic            i_halt_req,
  output logic [XLEN-1:0] o_pc,
  output logic            o_halt,
  output logic            o_commit_en
);

  logic [XLEN-1:0] next_pc;

  assign next_pc = i_branch_taken ? i_branch_target : o_pc + XLEN'(4);
  assign o_commit_en = ~o_halt;

  // ebreak leaves the PC parked on itself
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc   <= RESET_PC;
      o_halt <= 1'b0;
    end else if (o_commit_en) begin
      if (i_halt_req) begin
        o_halt <= 1'b1;
      end else begin
        o_pc <= next_pc;
      end
    end
  end

  a_pc_frozen: assert property (@(posedge i_clk) (o_halt && !i_rst) |=> $stable(o_pc))
    else $error("pc moved while halted");

endmodule

// File: rtl/core_lsu.sv
// load/store unit with the doubleword data memory and the write-back data mux
`timescale 1ns/1ps

module core_lsu import core_pkg::*; #(
  parameter int DMEM_WORDS = DMEM_DEPTH
) (
  input  logic            i_clk,
  input  logic [XLEN-1:0] i_addr,
  input  logic [XLEN-1:0] i_wdata,
  input  logic            i_wen,
  input  wb_sel_e         i_wb_sel,
  input  logic [XLEN-1:0] i_alu_result,
  input  logic [XLEN-1:0] i_pc,
  output logic [XLEN-1:0] o_rf_wdata
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]  mem [DMEM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [XLEN-1:0]  rdata;

  // address wraps at the memory size
  assign idx   = i_addr[IDX_W+2:3];
  assign rdata = mem[idx];

  always_ff @(posedge i_clk) begin
    if (i_wen) begin
      mem[idx] <= i_wdata;
    end
  end

  always_comb begin
    case (i_wb_sel)
      WB_MEM:  o_rf_wdata = rdata;
      WB_PC4:  o_rf_wdata = i_pc + XLEN'(4);
      default: o_rf_wdata = i_alu_result;
    endcase
  end

  a_store_aligned: assert property (@(posedge i_clk) i_wen |-> i_addr[2:0] == 3'b000)
    else $error("misaligned doubleword store at %h", i_addr);

endmodule

// File: rtl/core_pkg.sv
// shared widths, reset PC, memory depth and control encodings used across the core
package core_pkg;

  parameter int XLEN = 64;
  parameter int REG_AW = 5;

  // default data memory size in doublewords
  parameter int DMEM_DEPTH = 256;

  parameter logic [XLEN-1:0] RESET_PC = '0;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_JAL,
    BR_JALR
  } br_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef enum logic {
    SRC_B_REG,
    SRC_B_IMM
  } src_b_e;

endpackage

// File: rtl/core_regfile.sv
// general register file, two combinational reads and one write per clock, x0 reads zero
`timescale 1ns/1ps

module core_regfile import core_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_wen,
  input  logic [REG_AW-1:0] i_waddr,
  input  logic [XLEN-1:0]   i_wdata,
  input  logic [REG_AW-1:0] i_raddr1,
  input  logic [REG_AW-1:0] i_raddr2,
  output logic [XLEN-1:0]   o_rdata1,
  output logic [XLEN-1:0]   o_rdata2
);

  logic [XLEN-1:0] regs [2**REG_AW];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 2**REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 hardwired
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // decoder is expected to drop x0 destinations before they get here
  a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_rst) i_wen |-> i_waddr != '0)
    else $error("write to x0 reached the register file");

endmodule

// File: rtl/core_top.sv
// single-cycle RV64I core top, fetch port to an external instruction memory plus commit ports
`timescale 1ns/1ps

module core_top import core_pkg::*; #(
  parameter int DMEM_WORDS = DMEM_DEPTH
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [31:0]       i_inst,
  output logic [XLEN-1:0]   o_pc,
  output logic              o_rf_wen,
  output logic [REG_AW-1:0] o_rf_waddr,
  output logic [XLEN-1:0]   o_rf_wdata,
  output logic              o_halt
);

  logic              commit_en;
  logic [REG_AW-1:0] rs1, rs2, rd;
  logic [XLEN-1:0]   imm;
  alu_op_e           alu_op;
  src_b_e            src_b;
  br_op_e            br_op;
  wb_sel_e           wb_sel;
  logic              dec_rf_wen, dec_mem_wen, halt_req;
  logic [XLEN-1:0]   rs1_data, rs2_data;
  logic [XLEN-1:0]   alu_result, branch_target;
  logic              branch_taken;
  logic              mem_wen;

  // nothing architectural is written once halted
  assign o_rf_wen   = dec_rf_wen & commit_en;
  assign mem_wen    = dec_mem_wen & commit_en;
  assign o_rf_waddr = rd;

  core_ifu u_ifu (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_branch_taken(branch_taken), .i_branch_target(branch_target),
    .i_halt_req(halt_req),
    .o_pc(o_pc), .o_halt(o_halt), .o_commit_en(commit_en)
  );

  core_idu u_idu (
    .i_inst(i_inst),
    .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
    .o_alu_op(alu_op), .o_src_b(src_b), .o_br_op(br_op), .o_wb_sel(wb_sel),
    .o_rf_wen(dec_rf_wen), .o_mem_wen(dec_mem_wen), .o_halt_req(halt_req)
  );

  core_regfile u_regfile (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_wen(o_rf_wen), .i_waddr(rd), .i_wdata(o_rf_wdata),
    .i_raddr1(rs1), .i_raddr2(rs2),
    .o_rdata1(rs1_data), .o_rdata2(rs2_data)
  );

  core_exu u_exu (
    .i_pc(o_pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
    .i_alu_op(alu_op), .i_src_b(src_b), .i_br_op(br_op),
    .o_alu_result(alu_result), .o_branch_taken(branch_taken),
    .o_branch_target(branch_target)
  );

  core_lsu #(.DMEM_WORDS(DMEM_WORDS)) u_lsu (
    .i_clk(i_clk),
    .i_addr(alu_result), .i_wdata(rs2_data), .i_wen(mem_wen),
    .i_wb_sel(wb_sel), .i_alu_result(alu_result), .i_pc(o_pc),
    .o_rf_wdata(o_rf_wdata)
  );

endmodule

// File: tb/core_checker.sv
// reference model of the RV64I subset, steps on each cycle and compares the commit ports
`timescale 1ns/1ps

module core_checker import core_pkg::*; #(
  parameter int DMEM_WORDS = DMEM_DEPTH
) (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic [31:0]       i_inst,
  input  logic [XLEN-1:0]   i_pc,
  input  logic              i_rf_wen,
  input  logic [REG_AW-1:0] i_rf_waddr,
  input  logic [XLEN-1:0]   i_rf_wdata,
  input  logic              i_halt,
  output int                o_checks,
  output int                o_errors
);

  logic [XLEN-1:0] regs [32];
  logic [XLEN-1:0] mem [int];
  logic [XLEN-1:0] pc;
  logic            halted;

  initial begin
    o_checks = 0;
    o_errors = 0;
  end

  task automatic compare(input string name, input logic [XLEN-1:0] expected,
                         input logic [XLEN-1:0] actual);
    o_checks++;
    if (actual !== expected) begin
      o_errors++;
      $display("FAILED %s at pc %h: expected %h, actual %h", name, pc, expected, actual);
    end
  endtask

  task automatic step();
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [4:0]      rd;
    logic [XLEN-1:0] a, b, imm_i, imm_s, imm_b, imm_j, res, next_pc;
    logic            wen, st_en, halt_now, taken;
    int              slot;
    string           name;
    opc      = i_inst[6:0];
    f3       = i_inst[14:12];
    rd       = i_inst[11:7];
    a        = regs[i_inst[19:15]];
    b        = regs[i_inst[24:20]];
    imm_i    = XLEN'($signed(i_inst[31:20]));
    imm_s    = XLEN'($signed({i_inst[31:25], i_inst[11:7]}));
    imm_b    = XLEN'($signed({i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0}));
    imm_j    = XLEN'($signed({i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0}));
    res      = '0;
    wen      = 1'b0;
    st_en    = 1'b0;
    halt_now = 1'b0;
    taken    = 1'b0;
    slot     = 0;
    next_pc  = pc + 4;
    name     = "nop";
    case (opc)
      7'b0110011: begin
        wen = 1'b1;
        case ({i_inst[31:25], f3})
          10'h000: begin name = "add";  res = a + b; end
          10'h100: begin name = "sub";  res = a - b; end
          10'h002: begin name = "slt";  res = ($signed(a) < $signed(b)) ? 1 : 0; end
          10'h003: begin name = "sltu"; res = (a < b) ? 1 : 0; end
          10'h004: begin name = "xor";  res = a ^ b; end
          10'h006: begin name = "or";   res = a | b; end
          10'h007: begin name = "and";  res = a & b; end
          default: wen = 1'b0;
        endcase
      end
      7'b0010011: if (f3 == 3'b000) begin name = "addi"; wen = 1'b1; res = a + imm_i; end
      7'b0110111: begin name = "lui"; wen = 1'b1; res = XLEN'($signed({i_inst[31:12], 12'h0})); end
      7'b0000011: if (f3 == 3'b011) begin
        name = "ld";
        wen  = 1'b1;
        slot = int'(((a + imm_i) >> 3) % DMEM_WORDS);
        if (mem.exists(slot)) res = mem[slot];
        else if (!halted) begin
          o_errors++;
          $display("load from doubleword %0d, which was never stored", slot);
        end
      end
      7'b0100011: if (f3 == 3'b011) begin
        name  = "sd";
        st_en = 1'b1;
        slot  = int'(((a + imm_s) >> 3) % DMEM_WORDS);
      end
      7'b1100011: begin
        name = "branch";
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          default: taken = 1'b0;
        endcase
        if (taken) next_pc = pc + imm_b;
      end
      7'b1101111: begin name = "jal"; wen = 1'b1; res = pc + 4; next_pc = pc + imm_j; end
      7'b1100111: if (f3 == 3'b000) begin
        name    = "jalr";
        wen     = 1'b1;
        res     = pc + 4;
        next_pc = (a + imm_i) & ~XLEN'(1);
      end
      7'b1110011: if (i_inst == 32'h0010_0073) begin name = "ebreak"; halt_now = 1'b1; end
      default: ;
    endcase
    if (halt_now) next_pc = pc;
    // a halted core ignores whatever is fetched
    if (halted) begin
      wen     = 1'b0;
      st_en   = 1'b0;
      next_pc = pc;
    end
    if (rd == 5'd0) wen = 1'b0;
    compare({name, " rf_wen"}, wen, i_rf_wen);
    if (wen) begin
      compare({name, " rf_waddr"}, rd, i_rf_waddr);
      compare({name, " rf_wdata"}, res, i_rf_wdata);
      regs[rd] = res;
    end
    if (st_en) mem[slot] = b;
    pc = next_pc;
    if (halt_now) halted = 1'b1;
  endtask

  // commit outputs are settled by the falling edge
  always @(negedge i_clk) begin
    if (i_rst) begin
      foreach (regs[i]) regs[i] = '0;
      pc     = RESET_PC;
      halted = 1'b0;
    end else begin
      compare("pc", pc, i_pc);
      compare("halt", halted, i_halt);
      step();
    end
  end

endmodule

// File: tb/core_tb.sv
// testbench for the single-cycle core, feeds a seeded random program ending in ebreak
`timescale 1ns/1ps

module core_tb import core_pkg::*; ();

  localparam int N_INST = 2000;
  localparam int RST_CYCLES = 8;
  localparam int N_SLOTS = 16;
  localparam int DMEM_WORDS = 256;
  localparam int TIMEOUT_NS = (RST_CYCLES + N_INST + 20) * 40;
  localparam logic [31:0] NOP = 32'h0000_0013;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  logic              clk = 1'b0;
  logic              rst;
  logic [31:0]       inst;
  logic [XLEN-1:0]   pc;
  logic              rf_wen;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;
  logic              halt;
  int                checks;
  int                errors;

  always #20 clk = ~clk;

  core_top #(.DMEM_WORDS(DMEM_WORDS)) core_top_i (
    .i_clk(clk), .i_rst(rst), .i_inst(inst), .o_pc(pc),
    .o_rf_wen(rf_wen), .o_rf_waddr(rf_waddr), .o_rf_wdata(rf_wdata), .o_halt(halt)
  );

  core_checker #(.DMEM_WORDS(DMEM_WORDS)) u_checker (
    .i_clk(clk), .i_rst(rst), .i_inst(inst), .i_pc(pc),
    .i_rf_wen(rf_wen), .i_rf_waddr(rf_waddr), .i_rf_wdata(rf_wdata), .i_halt(halt),
    .o_checks(checks), .o_errors(errors)
  );

  // loads and stores stay on a few slots spread over the memory, based at x0
  function automatic logic [31:0] store_to_slot(input int slot, input logic [4:0] rs2);
    logic [11:0] off;
    off = 12'(slot * 128);
    return {off[11:5], rs2, 5'd0, 3'b011, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] random_inst();
    int          kind;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [20:0] jimm;
    logic [31:0] word;
    kind = $urandom_range(99);
    rd   = 5'($urandom);
    rs1  = 5'($urandom);
    rs2  = 5'($urandom);
    imm  = 12'($urandom);
    jimm = 21'($urandom);
    if (kind < 25) begin
      case ($urandom_range(6))
        0:       word = {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
        1:       word = {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
        2:       word = {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
        3:       word = {7'h00, rs2, rs1, 3'b011, rd, 7'b0110011};
        4:       word = {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
        5:       word = {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
        default: word = {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
      endcase
    end else if (kind < 40) begin
      word = {imm, rs1, 3'b000, rd, 7'b0010011};
    end else if (kind < 50) begin
      word = {20'($urandom), rd, 7'b0110111};
    end else if (kind < 62) begin
      word = {12'($urandom_range(N_SLOTS - 1) * 128), 5'd0, 3'b011, rd, 7'b0000011};
    end else if (kind < 74) begin
      word = store_to_slot($urandom_range(N_SLOTS - 1), rs2);
    end else if (kind < 92) begin
      case ($urandom_range(3))
        0:       f3 = 3'b000;
        1:       f3 = 3'b001;
        2:       f3 = 3'b100;
        default: f3 = 3'b101;
      endcase
      word = {imm[11], imm[9:4], rs2, rs1, f3, imm[3:0], imm[10], 7'b1100011};
    end else if (kind < 96) begin
      word = {jimm[20], jimm[10:1], jimm[11], jimm[19:12], rd, 7'b1101111};
    end else begin
      word = {imm, rs1, 3'b000, rd, 7'b1100111};
    end
    return word;
  endfunction

  initial begin
    void'($urandom(83));
    rst  = 1'b1;
    inst = NOP;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < N_INST; n++) begin
      if (n == N_INST - 1) inst <= EBREAK;
      else if (n < N_SLOTS) inst <= store_to_slot(n, 5'($urandom));
      else inst <= random_inst();
      @(posedge clk);
    end
    // instructions after ebreak must not commit
    inst <= random_inst();
    @(negedge clk);
    while (halt !== 1'b1) begin
      @(posedge clk);
      inst <= random_inst();
      @(negedge clk);
    end
    repeat (8) begin
      @(posedge clk);
      inst <= random_inst();
    end
    @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("the core did not halt within %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule
